/* alu.sv */
module alu import rvCorePkg::*; (
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] b,
	input aluOpT op,
	output logic [xlen-1:0] y,
	output logic lt,
	output logic ltu,
	output logic eq
);

	assign lt = $signed(a) < $signed(b);
	assign ltu = a < b;
	assign eq = a == b;

	always_comb begin
		case (op)
			ADD: y = a + b;
			SUB: y = a - b;
			AND: y = a & b;
			OR: y = a | b;
			XOR: y = a ^ b;
			SLT: y = xlen'(lt);
			SLTU: y = xlen'(ltu);
			SLL: y = a << b[4:0];
			SRL: y = a >> b[4:0];
			SRA: y = $signed(a) >>> b[4:0];
			PASSB: y = b;
			default: y = '0;
		endcase
	end

endmodule

/* coreIfs.sv */
interface hazardIf import rvCorePkg::*; ();
	logic [regAddrWidth-1:0] rs1D, rs2D, rs1E, rs2E;
	logic [regAddrWidth-1:0] rdE, rdM, rdW;
	logic regWriteM, regWriteW, loadE, takenE;
	logic stallF, stallD, flushD, flushE;
	fwdSelT fwdA, fwdB;

	modport pipe(
		output rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW, regWriteM, regWriteW, loadE, takenE,
		input stallF, stallD, flushD, flushE, fwdA, fwdB
	);
	modport hazard(
		input rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW, regWriteM, regWriteW, loadE, takenE,
		output stallF, stallD, flushD, flushE, fwdA, fwdB
	);
endinterface

interface debugIf import rvCorePkg::*; ();
	logic run, halted, retirePulse;
	logic [xlen-1:0] startPc, dbgData;
	logic [regAddrWidth-1:0] dbgAddr;

	modport ctrl(output run, startPc, dbgAddr, input halted, retirePulse, dbgData);
	modport core(input run, startPc, dbgAddr, output halted, retirePulse, dbgData);
endinterface

/* coreRegs.sv */
module coreRegs import rvCorePkg::*; #(
	parameter int retireCountWidth = 32
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apbAddrWidth-1:0] paddr,
	input logic [xlen-1:0] pwdata,
	output logic [xlen-1:0] prdata,
	debugIf.ctrl dbg
);
	apbRegT regSel;
	logic apbWrite, runSet;
	logic [retireCountWidth-1:0] retired;

	assign regSel = apbRegT'(paddr);
	assign apbWrite = psel && penable && pwrite;
	// a new run starts a fresh count
	assign runSet = apbWrite && regSel == CTRL && pwdata[0] && !dbg.run;

	always_ff @(posedge clk) begin
		if (reset) begin
			dbg.run <= 1'b0;
			dbg.startPc <= '0;
			dbg.dbgAddr <= '0;
			retired <= '0;
		end else begin
			if (apbWrite) begin
				case (regSel)
					CTRL: dbg.run <= pwdata[0];
					STARTPC: dbg.startPc <= pwdata;
					DBGREG: dbg.dbgAddr <= pwdata[regAddrWidth-1:0];
					default: ;
				endcase
			end
			if (runSet)
				retired <= '0;
			else if (dbg.retirePulse)
				retired <= retired + 1'b1;
		end
	end

	always_comb begin
		case (regSel)
			CTRL: prdata = xlen'(dbg.run);
			STARTPC: prdata = dbg.startPc;
			STATUS: prdata = xlen'(dbg.halted);
			RETIRED: prdata = xlen'(retired);
			DBGREG: prdata = dbg.dbgData;
			default: prdata = '0;
		endcase
	end

endmodule

/* dataPath.sv */
module dataPath import rvCorePkg::*; #(
	parameter int retireCountWidth = 32
) (
	input logic clk,
	input logic reset,
	output logic [xlen-1:0] imemAddr,
	input logic [xlen-1:0] imemData,
	output logic [xlen-1:0] dmemAddr,
	output logic [xlen-1:0] dmemWdata,
	output logic dmemWe,
	input logic [xlen-1:0] dmemRdata,
	hazardIf.pipe hz,
	debugIf.core dbg
);
	logic [xlen-1:0] pcF, pcD, pcE, instrD;
	logic runQ, stopF, fetchEn, runRise, haltSeenD;
	logic validD, validE, validM, validW;
	opcodeT opcodeD;
	aluOpT aluOpD, aluOpE;
	wbSelT wbSelD, wbSelE, wbSelM, wbSelW;
	logic regWriteD, memWriteD, isLoadD, isBranchD, isJalD, isJalrD, isHaltD, useImmD, usePcD;
	logic regWriteE, memWriteE, isLoadE, isBranchE, isJalE, isJalrE, isHaltE, useImmE, usePcE;
	logic regWriteM, memWriteM, isHaltM, regWriteW, isHaltW;
	logic [regAddrWidth-1:0] rs1AddrD, rs2AddrD, rdD, rs1UseD, rs2UseD;
	logic [regAddrWidth-1:0] rs1E, rs2E, rdE, rdM, rdW;
	logic [2:0] funct3D, funct3E;
	logic [xlen-1:0] immD, immE, rd1D, rd2D, rd1E, rd2E;
	logic [xlen-1:0] opA, opB, aluA, aluB, aluY, resultE, targetE;
	logic [xlen-1:0] resultM, storeDataM, resultW, memDataW, wbDataW;
	logic aluLt, aluLtu, aluEq, condE;

	// the retire counter in coreRegs needs at least one bit
	if (retireCountWidth < 1) begin : gWidthCheck
		$error("retireCountWidth must be at least 1");
	end

	assign runRise = dbg.run && !runQ;
	assign fetchEn = runQ && !stopF;
	assign haltSeenD = validD && isHaltD;
	assign imemAddr = pcF;

	always_ff @(posedge clk) begin
		if (reset) begin
			pcF <= '0;
			runQ <= 1'b0;
			stopF <= 1'b0;
			dbg.halted <= 1'b0;
			validD <= 1'b0;
			validE <= 1'b0;
			validM <= 1'b0;
			validW <= 1'b0;
		end else begin
			runQ <= dbg.run;
			if (runRise)
				pcF <= dbg.startPc;
			else if (hz.takenE)
				pcF <= targetE;
			else if (fetchEn && !hz.stallF)
				pcF <= pcF + 4;
			// ecall in decode stops fetch unless a branch squashes it
			if (runRise)
				stopF <= 1'b0;
			else if (haltSeenD && !hz.flushD)
				stopF <= 1'b1;
			if (runRise)
				dbg.halted <= 1'b0;
			else if (validW && isHaltW)
				dbg.halted <= 1'b1;
			if (hz.flushD)
				validD <= 1'b0;
			else if (!hz.stallD)
				validD <= fetchEn && !haltSeenD;
			validE <= validD && !hz.flushE;
			validM <= validE;
			validW <= validM;
		end
	end

	instrDecoder uDecoder (
		.instr(instrD), .opcode(opcodeD), .aluOp(aluOpD), .wbSel(wbSelD),
		.regWrite(regWriteD), .memWrite(memWriteD), .isLoad(isLoadD),
		.isBranch(isBranchD), .isJal(isJalD), .isJalr(isJalrD), .isHalt(isHaltD),
		.useImm(useImmD), .usePc(usePcD), .rs1(rs1AddrD), .rs2(rs2AddrD), .rd(rdD),
		.funct3(funct3D), .imm(immD)
	);

	regFile uRegFile (
		.clk(clk), .we(regWriteW && validW), .rs1Addr(rs1AddrD), .rs2Addr(rs2AddrD),
		.dbgAddr(dbg.dbgAddr), .rdAddr(rdW), .wd(wbDataW),
		.rs1Data(rd1D), .rs2Data(rd2D), .dbgData(dbg.dbgData)
	);

	// only real source operands take part in hazard checks
	assign rs1UseD = (validD && !(opcodeD inside {LUI, AUIPC, JAL, SYSTEM})) ? rs1AddrD : '0;
	assign rs2UseD = (validD && (opcodeD inside {OP, STORE, BRANCH})) ? rs2AddrD : '0;

	function automatic logic [xlen-1:0] fwdMux(input fwdSelT sel, input logic [xlen-1:0] regVal);
		case (sel)
			FROMMEM: return resultM;
			FROMWB: return wbDataW;
			default: return regVal;
		endcase
	endfunction

	always_comb begin
		opA = fwdMux(hz.fwdA, rd1E);
		opB = fwdMux(hz.fwdB, rd2E);
	end

	assign aluA = usePcE ? pcE : opA;
	assign aluB = useImmE ? immE : opB;

	alu uAlu (.a(aluA), .b(aluB), .op(aluOpE), .y(aluY), .lt(aluLt), .ltu(aluLtu), .eq(aluEq));

	always_comb begin
		case (funct3E)
			3'b000: condE = aluEq;
			3'b001: condE = !aluEq;
			3'b100: condE = aluLt;
			3'b101: condE = !aluLt;
			3'b110: condE = aluLtu;
			default: condE = !aluLtu;
		endcase
	end

	assign targetE = isJalrE ? {aluY[xlen-1:1], 1'b0} : pcE + immE;
	assign resultE = (wbSelE == PCPLUS4) ? pcE + 4 : aluY;

	always_ff @(posedge clk) begin
		if (!hz.stallD) begin
			instrD <= imemData;
			pcD <= pcF;
		end
		pcE <= pcD;
		rd1E <= rd1D;
		rd2E <= rd2D;
		immE <= immD;
		aluOpE <= aluOpD;
		wbSelE <= wbSelD;
		regWriteE <= regWriteD;
		memWriteE <= memWriteD;
		isLoadE <= isLoadD;
		isBranchE <= isBranchD;
		isJalE <= isJalD;
		isJalrE <= isJalrD;
		isHaltE <= isHaltD;
		useImmE <= useImmD;
		usePcE <= usePcD;
		rs1E <= rs1UseD;
		rs2E <= rs2UseD;
		rdE <= rdD;
		funct3E <= funct3D;
		resultM <= resultE;
		storeDataM <= opB;
		wbSelM <= wbSelE;
		regWriteM <= regWriteE;
		memWriteM <= memWriteE;
		isHaltM <= isHaltE;
		rdM <= rdE;
		resultW <= resultM;
		memDataW <= dmemRdata;
		wbSelW <= wbSelM;
		regWriteW <= regWriteM;
		isHaltW <= isHaltM;
		rdW <= rdM;
	end

	assign dmemAddr = resultM;
	assign dmemWdata = storeDataM;
	assign dmemWe = memWriteM && validM;
	assign wbDataW = (wbSelW == MEM) ? memDataW : resultW;

	assign hz.rs1D = rs1UseD;
	assign hz.rs2D = rs2UseD;
	assign hz.rs1E = rs1E;
	assign hz.rs2E = rs2E;
	assign hz.rdE = rdE;
	assign hz.rdM = rdM;
	assign hz.rdW = rdW;
	assign hz.regWriteM = regWriteM && validM;
	assign hz.regWriteW = regWriteW && validW;
	assign hz.loadE = isLoadE && validE;
	assign hz.takenE = validE && (isJalE || isJalrE || (isBranchE && condE));

	assign dbg.retirePulse = validW;

endmodule

/* hazardUnit.sv */
module hazardUnit import rvCorePkg::*; (
	hazardIf.hazard hz
);
	logic loadUse;

	// memory stage wins over writeback
	function automatic fwdSelT pickFwd(input logic [regAddrWidth-1:0] src);
		if (src == '0)
			return NONE;
		if (hz.regWriteM && hz.rdM == src)
			return FROMMEM;
		if (hz.regWriteW && hz.rdW == src)
			return FROMWB;
		return NONE;
	endfunction

	always_comb begin
		hz.fwdA = pickFwd(hz.rs1E);
		hz.fwdB = pickFwd(hz.rs2E);
	end

	assign loadUse = hz.loadE && hz.rdE != '0 && (hz.rdE == hz.rs1D || hz.rdE == hz.rs2D);

	assign hz.stallF = loadUse;
	assign hz.stallD = loadUse;
	assign hz.flushD = hz.takenE;
	// bubble into execute while the dependent op waits in decode
	assign hz.flushE = hz.takenE || loadUse;

endmodule

/* instrDecoder.sv */
module instrDecoder import rvCorePkg::*; (
	input logic [xlen-1:0] instr,
	output opcodeT opcode,
	output aluOpT aluOp,
	output wbSelT wbSel,
	output logic regWrite,
	output logic memWrite,
	output logic isLoad,
	output logic isBranch,
	output logic isJal,
	output logic isJalr,
	output logic isHalt,
	output logic useImm,
	output logic usePc,
	output logic [regAddrWidth-1:0] rs1,
	output logic [regAddrWidth-1:0] rs2,
	output logic [regAddrWidth-1:0] rd,
	output logic [2:0] funct3,
	output logic [xlen-1:0] imm
);
	logic [xlen-1:0] immI, immS, immB, immU, immJ;
	aluOpT intOp;

	assign opcode = opcodeT'(instr[6:0]);
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// addi has no sub form, so bit 30 only matters for OP
	always_comb begin
		case (funct3)
			3'b000: intOp = (opcode == OP && instr[30]) ? SUB : ADD;
			3'b001: intOp = SLL;
			3'b010: intOp = SLT;
			3'b011: intOp = SLTU;
			3'b100: intOp = XOR;
			3'b101: intOp = instr[30] ? SRA : SRL;
			3'b110: intOp = OR;
			default: intOp = AND;
		endcase
	end

	always_comb begin
		aluOp = ADD;
		wbSel = ALU;
		regWrite = 1'b0;
		memWrite = 1'b0;
		isLoad = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		isJalr = 1'b0;
		isHalt = 1'b0;
		useImm = 1'b0;
		usePc = 1'b0;
		imm = immI;
		case (opcode)
			OP: begin
				aluOp = intOp;
				regWrite = 1'b1;
			end
			OPIMM: begin
				aluOp = intOp;
				regWrite = 1'b1;
				useImm = 1'b1;
			end
			LUI: begin
				aluOp = PASSB;
				regWrite = 1'b1;
				useImm = 1'b1;
				imm = immU;
			end
			AUIPC: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				usePc = 1'b1;
				imm = immU;
			end
			LOAD: begin
				wbSel = MEM;
				regWrite = 1'b1;
				isLoad = 1'b1;
				useImm = 1'b1;
			end
			STORE: begin
				memWrite = 1'b1;
				useImm = 1'b1;
				imm = immS;
			end
			BRANCH: begin
				aluOp = SUB;
				isBranch = 1'b1;
				imm = immB;
			end
			JAL: begin
				wbSel = PCPLUS4;
				regWrite = 1'b1;
				isJal = 1'b1;
				imm = immJ;
			end
			JALR: begin
				wbSel = PCPLUS4;
				regWrite = 1'b1;
				isJalr = 1'b1;
				useImm = 1'b1;
			end
			// ecall halts the core
			SYSTEM: isHalt = 1'b1;
			default: ;
		endcase
	end

endmodule

/* regFile.sv */
module regFile import rvCorePkg::*; (
	input logic clk,
	input logic we,
	input logic [regAddrWidth-1:0] rs1Addr,
	input logic [regAddrWidth-1:0] rs2Addr,
	input logic [regAddrWidth-1:0] dbgAddr,
	input logic [regAddrWidth-1:0] rdAddr,
	input logic [xlen-1:0] wd,
	output logic [xlen-1:0] rs1Data,
	output logic [xlen-1:0] rs2Data,
	output logic [xlen-1:0] dbgData
);
	logic [xlen-1:0] regs [1 << regAddrWidth];

	// x0 is hardwired, a write in flight is seen by the reader
	function automatic logic [xlen-1:0] readPort(input logic [regAddrWidth-1:0] addr);
		if (addr == '0)
			return '0;
		if (we && addr == rdAddr)
			return wd;
		return regs[addr];
	endfunction

	always_comb begin
		rs1Data = readPort(rs1Addr);
		rs2Data = readPort(rs2Addr);
		dbgData = readPort(dbgAddr);
	end

	always_ff @(posedge clk) begin
		if (we && rdAddr != '0)
			regs[rdAddr] <= wd;
	end

endmodule

/* riscvSubsys.f */
rvCorePkg.sv
coreIfs.sv
instrDecoder.sv
alu.sv
regFile.sv
hazardUnit.sv
dataPath.sv
coreRegs.sv
riscvSubsys.sv
tbClock.sv
riscvSubsys_tb.sv

/* riscvSubsys.sv */
module riscvSubsys import rvCorePkg::*; #(
	parameter int retireCountWidth = 32
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apbAddrWidth-1:0] paddr,
	input logic [xlen-1:0] pwdata,
	output logic [xlen-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [xlen-1:0] imemAddr,
	input logic [xlen-1:0] imemData,
	output logic [xlen-1:0] dmemAddr,
	output logic [xlen-1:0] dmemWdata,
	output logic dmemWe,
	input logic [xlen-1:0] dmemRdata
);
	hazardIf hzBus ();
	debugIf dbgBus ();

	// no wait states, no error responses
	assign pready = 1'b1;
	assign pslverr = 1'b0;

	dataPath #(.retireCountWidth(retireCountWidth)) uDataPath (
		.clk(clk), .reset(reset), .imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe), .dmemRdata(dmemRdata),
		.hz(hzBus.pipe), .dbg(dbgBus.core)
	);

	coreRegs #(.retireCountWidth(retireCountWidth)) uCoreRegs (
		.clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .dbg(dbgBus.ctrl)
	);

	hazardUnit uHazardUnit (.hz(hzBus.hazard));

endmodule

/* riscvSubsys_tb.sv */
module riscvSubsys_tb import rvCorePkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int retireCountWidth = 32;
	localparam int numPrograms = 20;
	localparam int progWords = 64;
	localparam int cyclesPerProgram = progWords * 3 + 40 + 31 * 6 + 30;
	localparam int cycleLimit = (numPrograms + 1) * cyclesPerProgram;

	logic clk, reset;
	logic psel, penable, pwrite;
	logic [apbAddrWidth-1:0] paddr;
	logic [xlen-1:0] pwdata, prdata;
	logic pready, pslverr;
	logic [xlen-1:0] imemAddr, imemData, dmemAddr, dmemWdata, dmemRdata;
	logic dmemWe;

	logic [xlen-1:0] imem [128];
	logic [xlen-1:0] dmem [64];
	logic [xlen-1:0] modelMem [64];
	logic [xlen-1:0] modelRegs [32];
	logic [xlen-1:0] storeAddrQ [$];
	logic [xlen-1:0] storeDataQ [$];
	logic [retireCountWidth-1:0] retiredExp;
	logic [31:0] rngState = 32'had2f217b;
	int cycles = 0;

	tbClock uClock (.clk(clk), .reset(reset));

	riscvSubsys #(.retireCountWidth(retireCountWidth)) DUT (
		.clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.imemAddr(imemAddr), .imemData(imemData), .dmemAddr(dmemAddr),
		.dmemWdata(dmemWdata), .dmemWe(dmemWe), .dmemRdata(dmemRdata)
	);

	assign imemData = imem[imemAddr[8:2]];
	assign dmemRdata = dmem[dmemAddr[7:2]];

	always @(posedge clk) begin
		if (dmemWe)
			dmem[dmemAddr[7:2]] <= dmemWdata;
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic checkWord(input string name, input logic [xlen-1:0] got,
			input logic [xlen-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkCount(input string name, input logic [retireCountWidth-1:0] got,
			input logic [retireCountWidth-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	// every dmemWe cycle must match the next store of the model
	always @(negedge clk) begin
		if (dmemWe) begin
			if (storeAddrQ.size() == 0) begin
				$display("store seen on the data bus with no store expected");
				$display("SOME TESTS FAILED");
				$fatal(1);
			end else begin
				checkWord("dmemAddr", dmemAddr, storeAddrQ.pop_front());
				checkWord("dmemWdata", dmemWdata, storeDataQ.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout: the run did not finish within %0d cycles", cycleLimit);
		end
	end

	task automatic apbWrite(input apbRegT addr, input logic [xlen-1:0] data);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbRead(input apbRegT addr, output logic [xlen-1:0] data);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#10 data = prdata;
		checkFlag("pready", pready, 1'b1);
		checkFlag("pslverr", pslverr, 1'b0);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// reference interpreter that fills the expected store list and retire count
	task automatic runModel(input logic [31:0] startPc);
		logic [31:0] pc, ins, a, b, res, nextPc, addr;
		logic [31:0] immI, immS, immB, immJ;
		logic [2:0] f3;
		logic wr, done, cond;
		done = 1'b0;
		pc = startPc;
		retiredExp = '0;
		while (!done) begin
			ins = imem[pc[8:2]];
			f3 = ins[14:12];
			a = modelRegs[ins[19:15]];
			b = modelRegs[ins[24:20]];
			immI = {{20{ins[31]}}, ins[31:20]};
			immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			nextPc = pc + 4;
			wr = 1'b1;
			res = '0;
			case (ins[6:0])
				OP: res = aluModel(f3, ins[30], a, b);
				OPIMM: res = aluModel(f3, f3 == 3'd5 && ins[30], a, immI);
				LUI: res = {ins[31:12], 12'b0};
				AUIPC: res = pc + {ins[31:12], 12'b0};
				LOAD: begin
					addr = a + immI;
					res = modelMem[addr[7:2]];
				end
				STORE: begin
					wr = 1'b0;
					addr = a + immS;
					modelMem[addr[7:2]] = b;
					storeAddrQ.push_back(addr);
					storeDataQ.push_back(b);
				end
				BRANCH: begin
					wr = 1'b0;
					case (f3)
						3'd0: cond = a == b;
						3'd1: cond = a != b;
						3'd4: cond = $signed(a) < $signed(b);
						default: cond = $signed(a) >= $signed(b);
					endcase
					if (cond)
						nextPc = pc + immB;
				end
				JAL: begin
					res = pc + 4;
					nextPc = pc + immJ;
				end
				JALR: begin
					res = pc + 4;
					nextPc = (a + immI) & ~32'd1;
				end
				default: begin
					wr = 1'b0;
					done = 1'b1;
				end
			endcase
			if (wr && ins[11:7] != 5'd0)
				modelRegs[ins[11:7]] = res;
			retiredExp++;
			pc = nextPc;
		end
	endtask

	// mode 0 ALU only, mode 1 dense chains on x1..x3, mode 2 everything
	function automatic logic [31:0] genInstr(input int i, input int base, input int mode);
		logic [4:0] rd, rs1, rs2, shamt;
		logic [11:0] imm12;
		logic [2:0] f3;
		logic [12:0] offB;
		logic [20:0] offJ;
		int kind, t;
		rd = (mode == 1) ? 5'(1 + nextRand() % 3) : 5'(1 + nextRand() % 31);
		rs1 = (mode == 1) ? 5'(1 + nextRand() % 3) : 5'(nextRand() % 32);
		rs2 = (mode == 1) ? 5'(1 + nextRand() % 3) : 5'(nextRand() % 32);
		f3 = 3'(nextRand());
		shamt = 5'(nextRand());
		imm12 = 12'(nextRand());
		t = i + 1 + int'(nextRand() % (63 - i));
		offB = 13'(4 * (t - i));
		offJ = 21'(4 * (t - i));
		if (mode == 0)
			kind = nextRand() % 4;
		else if (mode == 1)
			kind = (nextRand() % 2 == 0) ? nextRand() % 2 : 4 + nextRand() % 2;
		else
			kind = nextRand() % 9;
		case (kind)
			0: return {((f3 == 3'd0 || f3 == 3'd5) && nextRand() % 2 == 1) ? 7'h20 : 7'h00,
					rs2, rs1, f3, rd, OP};
			1: begin
				if (f3 == 3'd1)
					imm12 = {7'h00, shamt};
				else if (f3 == 3'd5)
					imm12 = {(nextRand() % 2 == 1) ? 7'h20 : 7'h00, shamt};
				return {imm12, rs1, f3, rd, OPIMM};
			end
			2: return {20'(nextRand()), rd, LUI};
			3: return {20'(nextRand()), rd, AUIPC};
			4: return {12'(4 * (nextRand() % 64)), 5'd0, 3'b010, rd, LOAD};
			5: begin
				imm12 = 12'(4 * (nextRand() % 64));
				return {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], STORE};
			end
			6: begin
				f3 = (nextRand() % 2 == 1) ? {2'b10, f3[0]} : {2'b00, f3[0]};
				return {offB[12], offB[10:5], rs2, rs1, f3, offB[4:1], offB[11], BRANCH};
			end
			7: return {offJ[20], offJ[10:1], offJ[11], offJ[19:12], rd, JAL};
			default: return {12'(base + 4 * t), 5'd0, 3'b000, rd, JALR};
		endcase
	endfunction

	task automatic runProgram(input int base);
		logic [xlen-1:0] rdata;
		runModel(base);
		apbWrite(CTRL, 32'd0);
		apbWrite(STARTPC, base);
		apbWrite(CTRL, 32'd1);
		rdata = '0;
		while (rdata[0] !== 1'b1)
			apbRead(STATUS, rdata);
		if (storeAddrQ.size() != 0) begin
			$display("program at 0x%08h halted with %0d stores missing",
				base, storeAddrQ.size());
			$display("SOME TESTS FAILED");
			$fatal(1);
		end else begin
			apbRead(RETIRED, rdata);
			checkCount("RETIRED", rdata[retireCountWidth-1:0], retiredExp);
			for (int r = 1; r < 32; r++) begin
				apbWrite(DBGREG, r);
				apbRead(DBGREG, rdata);
				checkWord($sformatf("x%0d", r), rdata, modelRegs[r]);
			end
		end
	endtask

	initial begin
		logic [xlen-1:0] rdata;
		int base;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		for (int k = 0; k < 128; k++)
			imem[k] = {12'(k), 5'd0, 3'b000, 5'd0, OPIMM};
		for (int k = 0; k < 64; k++) begin
			dmem[k] = 32'h9e3779b9 * (k + 1) ^ {k[15:0], ~k[15:0]};
			modelMem[k] = dmem[k];
		end
		for (int k = 0; k < 32; k++)
			modelRegs[k] = '0;
		@(negedge reset);
		repeat (4) @(negedge clk);
		apbRead(STATUS, rdata);
		checkFlag("halted", rdata[0], 1'b0);
		apbRead(RETIRED, rdata);
		checkCount("RETIRED", rdata[retireCountWidth-1:0], '0);
		checkFlag("dmemWe", dmemWe, 1'b0);

		// first program gives every register a known value
		for (int r = 1; r < 32; r++)
			imem[r - 1] = {12'(nextRand()), 5'd0, 3'b000, 5'(r), OPIMM};
		imem[31] = 32'h00000073;
		runProgram(0);

		for (int p = 1; p <= numPrograms; p++) begin
			base = (p % 2) * 256;
			for (int i = 0; i < progWords - 1; i++)
				imem[base / 4 + i] = genInstr(i, base, p % 3);
			imem[base / 4 + progWords - 1] = 32'h00000073;
			runProgram(base);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end
endmodule

/* run.sh */
#!/bin/sh
# build and run the riscvSubsys testbench with Verilator
verilator --binary --timing -Wno-fatal -f riscvSubsys.f --top-module riscvSubsys_tb -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi
./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

/* rvCorePkg.sv */
package rvCorePkg;

	localparam int xlen = 32;
	localparam int regAddrWidth = 5;
	localparam int apbAddrWidth = 5;

	// RV32I major opcodes in use
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OPIMM  = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		SYSTEM = 7'b1110011
	} opcodeT;

	// PASSB forwards operand b, used by lui
	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, PASSB
	} aluOpT;

	typedef enum logic [1:0] {ALU, MEM, PCPLUS4} wbSelT;

	typedef enum logic [1:0] {NONE, FROMMEM, FROMWB} fwdSelT;

	typedef enum logic [apbAddrWidth-1:0] {
		CTRL    = 5'h00,
		STARTPC = 5'h04,
		STATUS  = 5'h08,
		RETIRED = 5'h0C,
		DBGREG  = 5'h10
	} apbRegT;

endpackage

/* tbClock.sv */
module tbClock (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset held for three rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end
endmodule
